//--- hdl/issue_pkg.sv
// Issue stage shared definitions.
// ALU opcode encoding and the default sizes used by the top level.

package issue_pkg;

   // ALU operations supported by the execute unit.
   typedef enum logic [1:0] {
      op_add = 2'd0,
      op_sub = 2'd1,
      op_and = 2'd2,
      op_xor = 2'd3
   } alu_op_t;

   // Log2 of the reservation station depth, 4 entries.
   localparam int DEF_RS_AW  = 2;

   // Physical register address width, 16 registers.
   localparam int DEF_PRF_AW = 4;

   // Datapath width.
   localparam int DEF_DW     = 16;

   // Instruction tag width.
   localparam int TAG_W      = 6;

endpackage

//--- hdl/prio_enc.sv
// Priority encoder.
// Returns the index of the lowest set request bit and a group-select flag.

`timescale 1ns/100ps

module prio_enc
#(
   parameter int AW = 2
)
(
   input  logic [2**AW-1:0] req,
   output logic [AW-1:0]    idx,
   output logic             any
);

   // Scan from the top so the lowest set bit wins.
   always_comb
   begin
      idx = '0;
      for (int i = 2**AW-1; i >= 0; i--)
      begin
         if (req[i])
            idx = AW'(i);
      end
   end

   assign any = |req;                            // Group select.

endmodule

//--- hdl/dispatch_busy.sv
// Dispatch with busy table.
// Accepts renamed instructions while the reservation station has room,
// forwards them as a push and tracks which physical registers are pending.

`timescale 1ns/100ps

module dispatch_busy
   import issue_pkg::*;
#(
   parameter int PRF_AW = 4,
   parameter int DW     = 16
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   // Instruction intake.
   input  logic                 in_valid,
   output logic                 in_ready,
   input  alu_op_t              op,
   input  logic [PRF_AW-1:0]    prs1,
   input  logic                 prs1_re,
   input  logic [PRF_AW-1:0]    prs2,
   input  logic                 prs2_re,
   input  logic [PRF_AW-1:0]    prd,
   input  logic                 prd_we,
   input  logic [DW-1:0]        imm,
   input  logic [TAG_W-1:0]     tag,
   // Reservation station push.
   input  logic                 rs_full,
   output logic                 push,
   output alu_op_t              push_op,
   output logic [PRF_AW-1:0]    push_prs1,
   output logic                 push_prs1_re,
   output logic [PRF_AW-1:0]    push_prs2,
   output logic                 push_prs2_re,
   output logic [PRF_AW-1:0]    push_prd,
   output logic                 push_prd_we,
   output logic [DW-1:0]        push_imm,
   output logic [TAG_W-1:0]     push_tag,
   // Writeback clear and busy table.
   input  logic                 wb_clr_en,
   input  logic [PRF_AW-1:0]    wb_prd,
   output logic [2**PRF_AW-1:0] busy_vec
);

   logic [2**PRF_AW-1:0] busy_nxt;

   assign in_ready = ~rs_full;
   assign push     = in_valid & ~rs_full;        // Transfer into the station.

   assign push_op      = op;
   assign push_prs1    = prs1;
   assign push_prs1_re = prs1_re;
   assign push_prs2    = prs2;
   assign push_prs2_re = prs2_re;
   assign push_prd     = prd;
   assign push_prd_we  = prd_we;
   assign push_imm     = imm;
   assign push_tag     = tag;

   // A register is never set and cleared in the same cycle,
   // since a busy prd is not handed out again.
   always_comb
   begin
      busy_nxt = busy_vec;
      if (wb_clr_en)
         busy_nxt[wb_prd] = 1'b0;                // Result written back.
      if (push && prd_we)
         busy_nxt[prd] = 1'b1;                   // Result now pending.
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         busy_vec <= '0;
      else
         busy_vec <= busy_nxt;
   end

endmodule

//--- hdl/issue_rs.sv
// Reservation station.
// Stores pushed instructions, wakes them up from the busy table, selects the
// lowest ready entry and holds it in the issue slot until the execute unit pops it.

`timescale 1ns/100ps

module issue_rs
   import issue_pkg::*;
#(
   parameter int RS_AW  = 2,
   parameter int PRF_AW = 4,
   parameter int DW     = 16
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   // Push from dispatch.
   input  logic                 push,
   input  alu_op_t              push_op,
   input  logic [PRF_AW-1:0]    push_prs1,
   input  logic                 push_prs1_re,
   input  logic [PRF_AW-1:0]    push_prs2,
   input  logic                 push_prs2_re,
   input  logic [PRF_AW-1:0]    push_prd,
   input  logic                 push_prd_we,
   input  logic [DW-1:0]        push_imm,
   input  logic [TAG_W-1:0]     push_tag,
   output logic                 rs_full,
   input  logic [2**PRF_AW-1:0] busy_vec,
   // Issue slot toward execute.
   output logic                 ex_valid,
   input  logic                 ex_pop,
   output alu_op_t              ex_op,
   output logic [PRF_AW-1:0]    ex_prs1,
   output logic                 ex_prs1_re,
   output logic [PRF_AW-1:0]    ex_prs2,
   output logic                 ex_prs2_re,
   output logic [PRF_AW-1:0]    ex_prd,
   output logic                 ex_prd_we,
   output logic [DW-1:0]        ex_imm,
   output logic [TAG_W-1:0]     ex_tag
);

   localparam int DEPTH = 2**RS_AW;

   alu_op_t           op_q      [DEPTH];
   logic [PRF_AW-1:0] prs1_q    [DEPTH];
   logic              prs1_re_q [DEPTH];
   logic [PRF_AW-1:0] prs2_q    [DEPTH];
   logic              prs2_re_q [DEPTH];
   logic [PRF_AW-1:0] prd_q     [DEPTH];
   logic              prd_we_q  [DEPTH];
   logic [DW-1:0]     imm_q     [DEPTH];
   logic [TAG_W-1:0]  tag_q     [DEPTH];

   logic [DEPTH-1:0]  free_q;
   logic [DEPTH-1:0]  rdy_vec;
   logic [RS_AW-1:0]  free_idx;
   logic [RS_AW-1:0]  rdy_idx;
   logic [RS_AW-1:0]  slot_idx_q;                // Entry held in the issue slot.
   logic              has_free;
   logic              has_rdy;
   logic              sel_en;
   logic              pop_fire;

   prio_enc #(.AW(RS_AW)) u_penc_free (.req(free_q),  .idx(free_idx), .any(has_free));
   prio_enc #(.AW(RS_AW)) u_penc_rdy  (.req(rdy_vec), .idx(rdy_idx),  .any(has_rdy));

   assign rs_full  = ~has_free;
   assign pop_fire = ex_valid & ex_pop;
   assign sel_en   = ~ex_valid | ex_pop;         // Slot empty or leaving.

   // Entry payload.
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         op_q[free_idx]      <= push_op;
         prs1_q[free_idx]    <= push_prs1;
         prs1_re_q[free_idx] <= push_prs1_re;
         prs2_q[free_idx]    <= push_prs2;
         prs2_re_q[free_idx] <= push_prs2_re;
         prd_q[free_idx]     <= push_prd;
         prd_we_q[free_idx]  <= push_prd_we;
         imm_q[free_idx]     <= push_imm;
         tag_q[free_idx]     <= push_tag;
      end
   end

   // Push and pop never touch the same entry.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         free_q <= '1;
      else
      begin
         if (push)
            free_q[free_idx] <= 1'b0;
         if (pop_fire)
            free_q[slot_idx_q] <= 1'b1;          // Freed when it leaves the slot.
      end
   end

   // Wakeup from the registered busy table.
   always_comb
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         rdy_vec[i] = ~free_q[i]
                    & ~(ex_valid && (slot_idx_q == RS_AW'(i)))
                    & (~prs1_re_q[i] | ~busy_vec[prs1_q[i]])
                    & (~prs2_re_q[i] | ~busy_vec[prs2_q[i]]);
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ex_valid <= 1'b0;
      else if (sel_en)
         ex_valid <= has_rdy;
   end

   // Issue slot payload.
   always_ff @(posedge clk)
   begin
      if (sel_en && has_rdy)
      begin
         slot_idx_q <= rdy_idx;
         ex_op      <= op_q[rdy_idx];
         ex_prs1    <= prs1_q[rdy_idx];
         ex_prs1_re <= prs1_re_q[rdy_idx];
         ex_prs2    <= prs2_q[rdy_idx];
         ex_prs2_re <= prs2_re_q[rdy_idx];
         ex_prd     <= prd_q[rdy_idx];
         ex_prd_we  <= prd_we_q[rdy_idx];
         ex_imm     <= imm_q[rdy_idx];
         ex_tag     <= tag_q[rdy_idx];
      end
   end

endmodule

//--- hdl/phys_regfile.sv
// Physical register file.
// Two asynchronous read ports and one clocked write port.

`timescale 1ns/100ps

module phys_regfile
#(
   parameter int PRF_AW = 4,
   parameter int DW     = 16
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [PRF_AW-1:0] raddr1,
   output logic [DW-1:0]     rdata1,
   input  logic [PRF_AW-1:0] raddr2,
   output logic [DW-1:0]     rdata2,
   input  logic              we,
   input  logic [PRF_AW-1:0] waddr,
   input  logic [DW-1:0]     wdata
);

   logic [DW-1:0] mem [2**PRF_AW];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < 2**PRF_AW; i++)
            mem[i] <= '0;
      end
      else if (we)
         mem[waddr] <= wdata;
   end

   assign rdata1 = mem[raddr1];
   assign rdata2 = mem[raddr2];

endmodule

//--- hdl/alu_exec.sv
// Integer execute unit.
// Pops the issue slot, reads operands and computes the ALU result, then holds
// it in an output register until the writeback port accepts it.

`timescale 1ns/100ps

module alu_exec
   import issue_pkg::*;
#(
   parameter int PRF_AW = 4,
   parameter int DW     = 16
)
(
   input  logic              clk,
   input  logic              rst_n,
   // Issue slot.
   input  logic              ex_valid,
   output logic              ex_pop,
   input  alu_op_t           ex_op,
   input  logic [PRF_AW-1:0] ex_prs1,
   input  logic              ex_prs1_re,
   input  logic [PRF_AW-1:0] ex_prs2,
   input  logic              ex_prs2_re,
   input  logic [PRF_AW-1:0] ex_prd,
   input  logic              ex_prd_we,
   input  logic [DW-1:0]     ex_imm,
   input  logic [TAG_W-1:0]  ex_tag,
   // Register file.
   output logic [PRF_AW-1:0] rf_raddr1,
   input  logic [DW-1:0]     rf_rdata1,
   output logic [PRF_AW-1:0] rf_raddr2,
   input  logic [DW-1:0]     rf_rdata2,
   output logic              rf_we,
   output logic              wb_clr_en,
   // Writeback.
   output logic              wb_valid,
   input  logic              wb_ready,
   output logic [TAG_W-1:0]  wb_tag,
   output logic [PRF_AW-1:0] wb_prd,
   output logic [DW-1:0]     wb_data
);

   logic [DW-1:0] opa;
   logic [DW-1:0] opb;
   logic [DW-1:0] result;
   logic          wb_prd_we;                     // Held result targets a register.
   logic          pop_fire;
   logic          wb_fire;

   assign rf_raddr1 = ex_prs1;
   assign rf_raddr2 = ex_prs2;

   assign opa = ex_prs1_re ? rf_rdata1 : '0;
   assign opb = ex_prs2_re ? rf_rdata2 : ex_imm; // Immediate form.

   always_comb
   begin
      case (ex_op)
         op_add:  result = opa + opb;
         op_sub:  result = opa - opb;
         op_and:  result = opa & opb;
         default: result = opa ^ opb;
      endcase
   end

   // Free to take a new entry when empty or draining this cycle.
   assign ex_pop   = ~wb_valid | wb_ready;
   assign pop_fire = ex_valid & ex_pop;
   assign wb_fire  = wb_valid & wb_ready;

   assign rf_we     = wb_fire & wb_prd_we;
   assign wb_clr_en = wb_fire & wb_prd_we;       // Releases the busy bit.

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         wb_valid <= 1'b0;
      else if (pop_fire)
         wb_valid <= 1'b1;
      else if (wb_ready)
         wb_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (pop_fire)
      begin
         wb_tag    <= ex_tag;
         wb_prd    <= ex_prd;
         wb_prd_we <= ex_prd_we;
         wb_data   <= result;
      end
   end

endmodule

//--- hdl/issue_top.sv
// Issue stage top level.
// Dispatch and busy table, reservation station, execute unit and register file.

`timescale 1ns/100ps

module issue_top
   import issue_pkg::*;
#(
   parameter int RS_AW  = DEF_RS_AW,
   parameter int PRF_AW = DEF_PRF_AW,
   parameter int DW     = DEF_DW
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_valid,
   output logic              in_ready,
   input  alu_op_t           op,
   input  logic [PRF_AW-1:0] prs1,
   input  logic              prs1_re,
   input  logic [PRF_AW-1:0] prs2,
   input  logic              prs2_re,
   input  logic [PRF_AW-1:0] prd,
   input  logic              prd_we,
   input  logic [DW-1:0]     imm,
   input  logic [TAG_W-1:0]  tag,
   output logic              wb_valid,
   input  logic              wb_ready,
   output logic [TAG_W-1:0]  wb_tag,
   output logic [PRF_AW-1:0] wb_prd,
   output logic [DW-1:0]     wb_data
);

   logic                 rs_full;
   logic                 push;
   alu_op_t              push_op;
   logic [PRF_AW-1:0]    push_prs1;
   logic                 push_prs1_re;
   logic [PRF_AW-1:0]    push_prs2;
   logic                 push_prs2_re;
   logic [PRF_AW-1:0]    push_prd;
   logic                 push_prd_we;
   logic [DW-1:0]        push_imm;
   logic [TAG_W-1:0]     push_tag;
   logic [2**PRF_AW-1:0] busy_vec;
   logic                 ex_valid;
   logic                 ex_pop;
   alu_op_t              ex_op;
   logic [PRF_AW-1:0]    ex_prs1;
   logic                 ex_prs1_re;
   logic [PRF_AW-1:0]    ex_prs2;
   logic                 ex_prs2_re;
   logic [PRF_AW-1:0]    ex_prd;
   logic                 ex_prd_we;
   logic [DW-1:0]        ex_imm;
   logic [TAG_W-1:0]     ex_tag;
   logic [PRF_AW-1:0]    rf_raddr1;
   logic [DW-1:0]        rf_rdata1;
   logic [PRF_AW-1:0]    rf_raddr2;
   logic [DW-1:0]        rf_rdata2;
   logic                 rf_we;
   logic                 wb_clr_en;

   dispatch_busy #(.PRF_AW(PRF_AW), .DW(DW)) u_dispatch (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .op           (op),
      .prs1         (prs1),
      .prs1_re      (prs1_re),
      .prs2         (prs2),
      .prs2_re      (prs2_re),
      .prd          (prd),
      .prd_we       (prd_we),
      .imm          (imm),
      .tag          (tag),
      .rs_full      (rs_full),
      .push         (push),
      .push_op      (push_op),
      .push_prs1    (push_prs1),
      .push_prs1_re (push_prs1_re),
      .push_prs2    (push_prs2),
      .push_prs2_re (push_prs2_re),
      .push_prd     (push_prd),
      .push_prd_we  (push_prd_we),
      .push_imm     (push_imm),
      .push_tag     (push_tag),
      .wb_clr_en    (wb_clr_en),
      .wb_prd       (wb_prd),
      .busy_vec     (busy_vec)
   );

   issue_rs #(.RS_AW(RS_AW), .PRF_AW(PRF_AW), .DW(DW)) u_rs (
      .clk          (clk),
      .rst_n        (rst_n),
      .push         (push),
      .push_op      (push_op),
      .push_prs1    (push_prs1),
      .push_prs1_re (push_prs1_re),
      .push_prs2    (push_prs2),
      .push_prs2_re (push_prs2_re),
      .push_prd     (push_prd),
      .push_prd_we  (push_prd_we),
      .push_imm     (push_imm),
      .push_tag     (push_tag),
      .rs_full      (rs_full),
      .busy_vec     (busy_vec),
      .ex_valid     (ex_valid),
      .ex_pop       (ex_pop),
      .ex_op        (ex_op),
      .ex_prs1      (ex_prs1),
      .ex_prs1_re   (ex_prs1_re),
      .ex_prs2      (ex_prs2),
      .ex_prs2_re   (ex_prs2_re),
      .ex_prd       (ex_prd),
      .ex_prd_we    (ex_prd_we),
      .ex_imm       (ex_imm),
      .ex_tag       (ex_tag)
   );

   alu_exec #(.PRF_AW(PRF_AW), .DW(DW)) u_exec (
      .clk          (clk),
      .rst_n        (rst_n),
      .ex_valid     (ex_valid),
      .ex_pop       (ex_pop),
      .ex_op        (ex_op),
      .ex_prs1      (ex_prs1),
      .ex_prs1_re   (ex_prs1_re),
      .ex_prs2      (ex_prs2),
      .ex_prs2_re   (ex_prs2_re),
      .ex_prd       (ex_prd),
      .ex_prd_we    (ex_prd_we),
      .ex_imm       (ex_imm),
      .ex_tag       (ex_tag),
      .rf_raddr1    (rf_raddr1),
      .rf_rdata1    (rf_rdata1),
      .rf_raddr2    (rf_raddr2),
      .rf_rdata2    (rf_rdata2),
      .rf_we        (rf_we),
      .wb_clr_en    (wb_clr_en),
      .wb_valid     (wb_valid),
      .wb_ready     (wb_ready),
      .wb_tag       (wb_tag),
      .wb_prd       (wb_prd),
      .wb_data      (wb_data)
   );

   // Written at the same edge the writeback port accepts the result.
   phys_regfile #(.PRF_AW(PRF_AW), .DW(DW)) u_prf (
      .clk          (clk),
      .rst_n        (rst_n),
      .raddr1       (rf_raddr1),
      .rdata1       (rf_rdata1),
      .raddr2       (rf_raddr2),
      .rdata2       (rf_rdata2),
      .we           (rf_we),
      .waddr        (wb_prd),
      .wdata        (wb_data)
   );

endmodule

//--- sim/tb_clk_gen.sv
// Testbench clock and reset.
// Free-running clock, reset held low for the first two cycles.

`timescale 1ns/100ps

module tb_clk_gen
#(
   parameter int PERIOD = 40
)
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;                           // Released just after the edge.
   end

endmodule

//--- sim/tb_issue.sv
// Issue stage testbench.
// Random instruction stream with dependent chains and writeback stalls,
// checked against a model of the register file, busy table and in-flight tags.

`timescale 1ns/100ps

module tb_issue
   import issue_pkg::*;
();

   localparam int RS_AW     = DEF_RS_AW;
   localparam int PRF_AW    = DEF_PRF_AW;
   localparam int DW        = DEF_DW;
   localparam int DEPTH     = 2**RS_AW;
   localparam int NREG      = 2**PRF_AW;
   localparam int NTAG      = 2**TAG_W;
   localparam int PERIOD    = 40;
   localparam int DRV_DLY   = 2;
   localparam int N_LOADS   = NREG;             // One immediate load per register.
   localparam int N_INSTR   = 160;
   localparam int MAX_STALL = 15;
   localparam int WDOG_CYC  = N_INSTR * (MAX_STALL + 8) + 100;

   logic              clk;
   logic              rst_n;
   logic              in_valid;
   logic              in_ready;
   alu_op_t           op;
   logic [PRF_AW-1:0] prs1;
   logic              prs1_re;
   logic [PRF_AW-1:0] prs2;
   logic              prs2_re;
   logic [PRF_AW-1:0] prd;
   logic              prd_we;
   logic [DW-1:0]     imm;
   logic [TAG_W-1:0]  tag;
   logic              wb_valid;
   logic              wb_ready;
   logic [TAG_W-1:0]  wb_tag;
   logic [PRF_AW-1:0] wb_prd;
   logic [DW-1:0]     wb_data;

   // Reference model state.
   integer            seed = 32'hb55d_92a6;
   logic [DW-1:0]     shadow   [NREG];         // Program-order register values.
   bit                busy_m   [NREG];
   int                src_cnt  [NREG];         // In-flight readers per register.
   bit                pending  [NTAG];
   logic [DW-1:0]     exp_data [NTAG];
   logic [PRF_AW-1:0] exp_prd  [NTAG];
   bit                exp_we   [NTAG];
   logic [PRF_AW-1:0] src1     [NTAG];
   bit                src1_en  [NTAG];
   logic [PRF_AW-1:0] src2     [NTAG];
   bit                src2_en  [NTAG];
   int                sent;
   int                done_cnt;
   int                outstanding;
   int                stall_left;
   bit                accepted;
   logic [PRF_AW-1:0] last_prd;

   tb_clk_gen #(.PERIOD(PERIOD)) u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   issue_top #(.RS_AW(RS_AW), .PRF_AW(PRF_AW), .DW(DW)) u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .op       (op),
      .prs1     (prs1),
      .prs1_re  (prs1_re),
      .prs2     (prs2),
      .prs2_re  (prs2_re),
      .prd      (prd),
      .prd_we   (prd_we),
      .imm      (imm),
      .tag      (tag),
      .wb_valid (wb_valid),
      .wb_ready (wb_ready),
      .wb_tag   (wb_tag),
      .wb_prd   (wb_prd),
      .wb_data  (wb_data)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic value_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      abort_run($sformatf("error at %0t: %s is %0h, expected %0h", $time, name, got, exp));
   endtask

   // Disabled sources read 0 and imm stands in for a missing rs2.
   function automatic logic [DW-1:0] model_result(alu_op_t f_op, bit re1, logic [DW-1:0] v1,
                                                   bit re2, logic [DW-1:0] v2,
                                                   logic [DW-1:0] f_imm);
      logic [DW-1:0] a;
      logic [DW-1:0] b;
      a = re1 ? v1 : '0;
      b = re2 ? v2 : f_imm;
      case (f_op)
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         default: return a ^ b;
      endcase
   endfunction

   // A register that is neither pending nor still to be read.
   function automatic int pick_dest();
      int start;
      int r;
      start = $random(seed) & (NREG - 1);
      for (int k = 0; k < NREG; k++)
      begin
         r = (start + k) % NREG;
         if (!busy_m[r] && src_cnt[r] == 0)
            return r;
      end
      return -1;
   endfunction

   task automatic drive_wb_ready();
      if (stall_left > 0)
      begin
         wb_ready = 1'b0;
         stall_left--;
      end
      else if (sent > N_LOADS && ($random(seed) & 7) == 0)
      begin
         wb_ready = 1'b0;
         stall_left = $random(seed) & MAX_STALL; // Stretch length.
      end
      else
         wb_ready = 1'b1;
   endtask

   task automatic next_instr();
      int d;
      in_valid = 1'b0;
      if (sent == N_INSTR)
         return;
      if (sent >= N_LOADS && ($random(seed) & 7) == 0)
         return;                                 // Idle cycle.
      if (sent < N_LOADS)
      begin
         op      = op_add;
         prs1    = PRF_AW'($random(seed));
         prs1_re = 1'b0;
         prs2    = PRF_AW'($random(seed));
         prs2_re = 1'b0;
         prd     = PRF_AW'(sent);
         prd_we  = 1'b1;
      end
      else
      begin
         d = pick_dest();
         if (d < 0)
            return;
         op      = alu_op_t'(2'($random(seed)));
         prs1    = (($random(seed) & 1) != 0) ? last_prd : PRF_AW'($random(seed));
         prs1_re = ($random(seed) & 3) != 0;
         prs2    = (($random(seed) & 1) != 0) ? last_prd : PRF_AW'($random(seed));
         prs2_re = ($random(seed) & 1) != 0;
         prd     = PRF_AW'(d);
         prd_we  = ($random(seed) & 7) != 0;
         if (prs1 == prd)
            prs1_re = 1'b0;                      // Would wait on itself.
         if (prs2 == prd)
            prs2_re = 1'b0;
      end
      imm      = DW'($random(seed));
      tag      = TAG_W'(sent);
      last_prd = prd;
      in_valid = 1'b1;
      sent++;
   endtask

   task automatic dispatch_model();
      int t;
      t = int'(tag);
      exp_data[t] = model_result(op, prs1_re, shadow[prs1], prs2_re, shadow[prs2], imm);
      exp_prd[t]  = prd;
      exp_we[t]   = prd_we;
      src1[t]     = prs1;
      src1_en[t]  = prs1_re;
      src2[t]     = prs2;
      src2_en[t]  = prs2_re;
      pending[t]  = 1'b1;
      if (prs1_re)
         src_cnt[prs1]++;
      if (prs2_re)
         src_cnt[prs2]++;
      if (prd_we)
      begin
         shadow[prd] = exp_data[t];
         busy_m[prd] = 1'b1;
      end
      outstanding++;
   endtask

   task automatic retire_check();
      int t;
      t = int'(wb_tag);
      if (!pending[t])
         abort_run($sformatf("error at %0t: tag %0d written back but not in flight", $time, t));
      assert (wb_data == exp_data[t])
         else value_error("wb_data", 32'(wb_data), 32'(exp_data[t]));
      assert (wb_prd == exp_prd[t])
         else value_error("wb_prd", 32'(wb_prd), 32'(exp_prd[t]));
      // Producers of both sources must be back already.
      assert (!(src1_en[t] && busy_m[src1[t]]) && !(src2_en[t] && busy_m[src2[t]]))
         else abort_run($sformatf("error at %0t: tag %0d written back before its producer",
                                  $time, t));
      if (exp_we[t])
         busy_m[exp_prd[t]] = 1'b0;
      if (src1_en[t])
         src_cnt[src1[t]]--;
      if (src2_en[t])
         src_cnt[src2[t]]--;
      pending[t] = 1'b0;
      outstanding--;
      done_cnt++;
   endtask

   // Writeback fields hold while the port is stalled.
   assert property (@(posedge clk) disable iff (!rst_n)
      (wb_valid && !wb_ready) |=>
         (wb_valid && $stable(wb_tag) && $stable(wb_prd) && $stable(wb_data)))
      else abort_run($sformatf("error at %0t: writeback changed while wb_ready was low", $time));

   // Handshakes are sampled mid-cycle, where inputs and outputs are settled.
   always @(negedge clk)
   begin : monitor
      bit exp_rdy;
      if (rst_n)
      begin
         exp_rdy = (outstanding - int'(wb_valid)) < DEPTH;
         assert (in_ready == exp_rdy)
            else value_error("in_ready", 32'(in_ready), 32'(exp_rdy));
         accepted = in_valid && in_ready;
         if (wb_valid && wb_ready)
            retire_check();
         if (accepted)
            dispatch_model();
      end
   end

   initial
   begin : drive
      in_valid = 1'b0;
      op       = op_add;
      prs1     = '0;
      prs1_re  = 1'b0;
      prs2     = '0;
      prs2_re  = 1'b0;
      prd      = '0;
      prd_we   = 1'b0;
      imm      = '0;
      tag      = '0;
      wb_ready = 1'b0;
      last_prd = '0;
      for (int i = 0; i < NREG; i++)
         shadow[i] = '0;
      wait (rst_n);
      assert (in_ready === 1'b1)
         else value_error("in_ready", 32'(in_ready), 32'd1);
      assert (wb_valid === 1'b0)
         else value_error("wb_valid", 32'(wb_valid), 32'd0);
      while (done_cnt < N_INSTR)
      begin
         @(posedge clk);
         #DRV_DLY;
         drive_wb_ready();
         if (!in_valid || accepted)
            next_instr();
      end
      // Quiet period after the last writeback.
      repeat (DEPTH + 2)
      begin
         @(posedge clk);
         #DRV_DLY;
         wb_ready = 1'b1;
      end
      if (wb_valid !== 1'b0)
         value_error("wb_valid", 32'(wb_valid), 32'd0);
      else
      begin
         $display("PASS: all tests");
         $finish;
      end
   end

   initial
   begin : watchdog
      #(WDOG_CYC * PERIOD);
      abort_run($sformatf("error at %0t: watchdog expired with %0d of %0d written back",
                          $time, done_cnt, N_INSTR));
   end

endmodule

//--- tb.f
hdl/issue_pkg.sv
hdl/prio_enc.sv
hdl/dispatch_busy.sv
hdl/issue_rs.sv
hdl/phys_regfile.sv
hdl/alu_exec.sv
hdl/issue_top.sv
sim/tb_clk_gen.sv
sim/tb_issue.sv

//--- run_sim.sh
#!/bin/sh
# Builds the issue stage testbench with Verilator and runs it.
# The run fails when the log holds the fail message or lacks the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module tb_issue \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_issue > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
